/* logic/scan_pkg.sv */
package scan_pkg;

  // Number of literal rules in the scanner
  localparam int NUM_RULES = 2;

  // Input stall after an end-of-packet beat
  // Covers the rule context pipeline up to the state save
  localparam int DRAIN_CYCLES = 3;

  // One payload character
  typedef logic [7:0] byte_t;

  // Stream identifier, selects one of 64 context entries
  typedef logic [5:0] stream_id_t;

  // Automaton state, count of pattern characters matched so far
  // 4 bits allow patterns up to 15 characters
  typedef logic [3:0] dfa_state_t;

  // Per-rule packet count, wraps
  typedef logic [15:0] match_count_t;

  // One enable or fired bit per rule
  typedef logic [NUM_RULES-1:0] rule_mask_t;

  // Stream tracker FSM
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    STREAM,
    DRAIN
  } tracker_state_t;

endpackage

/* logic/literal_dfa.sv */
`timescale 1ns/1ps

module literal_dfa #(
  parameter int PAT_LEN = 5,
  parameter logic [8*PAT_LEN-1:0] PATTERN = "login"
) (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::byte_t     char_in,
  input  logic                char_vld,
  input  scan_pkg::dfa_state_t state_in,
  input  logic                state_vld,
  output scan_pkg::dfa_state_t state_out,
  output logic                accept_out
);
  import scan_pkg::*;

  // State value that means the whole pattern was seen
  localparam dfa_state_t FINAL_STATE = dfa_state_t'(PAT_LEN);

  dfa_state_t cur_state;
  dfa_state_t next_state;
  dfa_state_t state_q;
  byte_t      first_char;
  byte_t      expect_char;
  logic       hit;
  logic       accept_q;

  // First character sits in the top byte of the packed literal
  assign first_char = PATTERN[8*PAT_LEN-1 -: 8];

  // A restored state overrides the held one for this cycle
  assign cur_state = state_vld ? state_in : state_q;

  // Character that would extend the current partial match
  always_comb begin
    if (int'(cur_state) < PAT_LEN)
      expect_char = PATTERN[8*(PAT_LEN-1-int'(cur_state)) +: 8];
    else
      expect_char = first_char;
  end

  // Fallback goes to 1 or 0 only, first letter never repeats in the pattern
  always_comb begin
    next_state = cur_state;
    if (char_vld)
    begin
      if (char_in == expect_char)
        next_state = cur_state + dfa_state_t'(1);
      else if (char_in == first_char)
        next_state = dfa_state_t'(1);
      else
        next_state = '0;
    end
  end

  assign hit = char_vld && (next_state == FINAL_STATE);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q  <= '0;
      accept_q <= 1'b0;
    end
    else
    begin
      // Full match restarts the automaton
      state_q  <= hit ? dfa_state_t'(0) : next_state;
      accept_q <= hit;
    end
  end

  assign state_out  = state_q;
  assign accept_out = accept_q;

endmodule

/* logic/rule_context.sv */
`timescale 1ns/1ps

module rule_context #(
  parameter int PAT_LEN = 5,
  parameter logic [8*PAT_LEN-1:0] PATTERN = "login"
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_state,
  input  logic                   flush,
  input  scan_pkg::stream_id_t   stream_id,
  input  logic                   char_vld,
  input  scan_pkg::byte_t        char_data,
  input  logic                   eop,
  input  logic                   enable,
  output logic                   fired,
  output scan_pkg::match_count_t count
);
  import scan_pkg::*;

  // One context entry per stream ID
  localparam int DEPTH = 2**$bits(stream_id_t);

  // Saved automaton state and saved flag per stream
  dfa_state_t       state_mem [DEPTH];
  logic [DEPTH-1:0] saved_vld;

  // Restore stage
  dfa_state_t restore_state;
  logic       restore_vld;

  // Automaton input registers
  byte_t      char_in_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_vld_r;

  // Automaton outputs and their registers
  dfa_state_t state_out;
  logic       accept_out;
  dfa_state_t state_out_r;
  logic       accept_out_r;

  // eop delayed to line up with accept_out_r
  logic [2:0] eop_pipe;
  logic       eop_last;

  logic         fired_q;
  match_count_t count_q;

  assign eop_last = eop_pipe[2];

  // New stream or flushed stream starts from state 0
  always_ff @(posedge clk)
  begin
    if (load_state)
    begin
      if (flush || !saved_vld[stream_id])
        restore_state <= '0;
      else
        restore_state <= state_mem[stream_id];
    end
  end

  // Save only for enabled rules, disabled packets keep the older state
  always_ff @(posedge clk)
  begin
    if (eop_last && enable)
      state_mem[stream_id] <= state_out_r;
  end

  // Register automaton inputs and outputs for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      restore_vld  <= 1'b0;
      char_vld_r   <= 1'b0;
      state_vld_r  <= 1'b0;
      accept_out_r <= 1'b0;
      eop_pipe     <= '0;
    end
    else
    begin
      restore_vld  <= load_state;
      char_vld_r   <= char_vld;
      state_vld_r  <= restore_vld;
      accept_out_r <= accept_out;
      eop_pipe     <= {eop_pipe[1:0], eop};
    end
  end

  // Payload side of the same stages
  always_ff @(posedge clk)
  begin
    char_in_r   <= char_data;
    state_in_r  <= restore_state;
    state_out_r <= state_out;
  end

  literal_dfa #(
    .PAT_LEN (PAT_LEN),
    .PATTERN (PATTERN)
  ) dfa_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_in    (char_in_r),
    .char_vld   (char_vld_r),
    .state_in   (state_in_r),
    .state_vld  (state_vld_r),
    .state_out  (state_out),
    .accept_out (accept_out)
  );

  // Per-packet flag and packet tally
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fired_q   <= 1'b0;
      count_q   <= '0;
      saved_vld <= '0;
    end
    else
    begin
      // Start of packet clears the flag
      if (load_state)
        fired_q <= 1'b0;
      if (accept_out_r)
        fired_q <= 1'b1;
      if (eop_last)
      begin
        if (enable)
        begin
          // Last character's accept counts too
          count_q              <= count_q + match_count_t'(fired_q | accept_out_r);
          saved_vld[stream_id] <= 1'b1;
        end
        else
          fired_q <= 1'b0;
      end
    end
  end

  assign fired = fired_q;
  assign count = count_q;

endmodule

/* logic/stream_tracker.sv */
`timescale 1ns/1ps

module stream_tracker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  scan_pkg::byte_t      in_data,
  input  logic                 in_sop,
  input  logic                 in_eop,
  input  scan_pkg::stream_id_t in_stream,
  input  logic                 in_flush,
  input  scan_pkg::rule_mask_t in_enable,
  output logic                 in_ready,
  output logic                 load_state,
  output logic                 flush,
  output scan_pkg::stream_id_t stream_id,
  output scan_pkg::rule_mask_t enable,
  output logic                 char_vld,
  output scan_pkg::byte_t      char_data,
  output logic                 eop,
  output logic                 res_valid,
  output scan_pkg::stream_id_t res_stream
);
  import scan_pkg::*;

  // eop to result delay, matches the rule context pipeline
  localparam int RES_DELAY = 3;
  localparam int DRAIN_W   = $clog2(DRAIN_CYCLES + 1);

  tracker_state_t       state_q;
  tracker_state_t       state_d;
  logic                 ready_q;
  logic                 beat_xfer;
  logic                 start_pkt;
  logic [DRAIN_W-1:0]   drain_cnt;
  logic [RES_DELAY-1:0] eop_pipe;

  // Idle with a sop beat waiting holds it back for the load cycle
  assign in_ready  = ready_q && !(state_q == IDLE && in_valid && in_sop);
  assign beat_xfer = in_valid && in_ready;
  assign start_pkt = (state_q == IDLE) && in_valid && in_sop;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_pkt) state_d = LOAD;
      LOAD:    state_d = STREAM;
      STREAM:  if (beat_xfer && in_eop) state_d = DRAIN;
      DRAIN:   if (drain_cnt == '0) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q    <= IDLE;
      ready_q    <= 1'b0;
      load_state <= 1'b0;
      char_vld   <= 1'b0;
      eop        <= 1'b0;
      drain_cnt  <= '0;
      eop_pipe   <= '0;
      res_valid  <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      // Ready only in IDLE and STREAM
      ready_q    <= (state_d == IDLE) || (state_d == STREAM);
      load_state <= start_pkt;
      // Non-sop beats in IDLE are dropped here
      char_vld   <= beat_xfer && (state_q == STREAM);
      eop        <= beat_xfer && (state_q == STREAM) && in_eop;
      if (state_q == STREAM && state_d == DRAIN)
        drain_cnt <= DRAIN_W'(DRAIN_CYCLES - 1);
      else if (state_q == DRAIN && drain_cnt != '0)
        drain_cnt <= drain_cnt - 1'b1;
      eop_pipe   <= {eop_pipe[RES_DELAY-2:0], eop};
      res_valid  <= eop_pipe[RES_DELAY-1];
    end
  end

  // Packet fields held from the sop beat on
  always_ff @(posedge clk)
  begin
    if (start_pkt)
    begin
      stream_id <= in_stream;
      flush     <= in_flush;
      enable    <= in_enable;
    end
    if (beat_xfer)
      char_data <= in_data;
    // Taken before a following packet can replace stream_id
    if (eop_pipe[RES_DELAY-1])
      res_stream <= stream_id;
  end

endmodule

/* logic/payload_scanner.sv */
`timescale 1ns/1ps

module payload_scanner #(
  parameter int RULE0_LEN = 5,
  parameter logic [8*RULE0_LEN-1:0] RULE0_PATTERN = "login",
  parameter int RULE1_LEN = 4,
  parameter logic [8*RULE1_LEN-1:0] RULE1_PATTERN = "pass"
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  scan_pkg::byte_t        in_data,
  input  logic                   in_sop,
  input  logic                   in_eop,
  input  scan_pkg::stream_id_t   in_stream,
  input  logic                   in_flush,
  input  scan_pkg::rule_mask_t   in_enable,
  output logic                   res_valid,
  output scan_pkg::stream_id_t   res_stream,
  output scan_pkg::rule_mask_t   res_fired,
  output scan_pkg::match_count_t count0,
  output scan_pkg::match_count_t count1
);
  import scan_pkg::*;

  // Shared tracker outputs
  logic       load_state;
  logic       flush;
  stream_id_t stream_id;
  rule_mask_t enable;
  logic       char_vld;
  byte_t      char_data;
  logic       eop;

  stream_tracker tracker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_stream  (in_stream),
    .in_flush   (in_flush),
    .in_enable  (in_enable),
    .in_ready   (in_ready),
    .load_state (load_state),
    .flush      (flush),
    .stream_id  (stream_id),
    .enable     (enable),
    .char_vld   (char_vld),
    .char_data  (char_data),
    .eop        (eop),
    .res_valid  (res_valid),
    .res_stream (res_stream)
  );

  // Rule 0
  rule_context #(
    .PAT_LEN (RULE0_LEN),
    .PATTERN (RULE0_PATTERN)
  ) rule0_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .flush      (flush),
    .stream_id  (stream_id),
    .char_vld   (char_vld),
    .char_data  (char_data),
    .eop        (eop),
    .enable     (enable[0]),
    .fired      (res_fired[0]),
    .count      (count0)
  );

  // Rule 1
  rule_context #(
    .PAT_LEN (RULE1_LEN),
    .PATTERN (RULE1_PATTERN)
  ) rule1_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_state (load_state),
    .flush      (flush),
    .stream_id  (stream_id),
    .char_vld   (char_vld),
    .char_data  (char_data),
    .eop        (eop),
    .enable     (enable[1]),
    .fired      (res_fired[1]),
    .count      (count1)
  );

endmodule

/* verification/payload_scanner_chk.sv */
`timescale 1ns/1ps

module payload_scanner_chk (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic                     in_ready,
  input  scan_pkg::byte_t          in_data,
  input  logic                     in_sop,
  input  logic                     in_eop,
  input  scan_pkg::stream_id_t     in_stream,
  input  logic                     in_flush,
  input  scan_pkg::rule_mask_t     in_enable,
  input  scan_pkg::tracker_state_t state,
  input  logic                     load_state,
  input  logic                     char_vld,
  input  logic                     eop
);
  import scan_pkg::*;

  // All sender fields of one beat, packed for the stability check
  logic [$bits(byte_t)+$bits(stream_id_t)+$bits(rule_mask_t)+2:0] beat_fields;

  assign beat_fields = {in_data, in_sop, in_eop, in_stream, in_flush, in_enable};

  // A stalled beat stays presented and unchanged
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(beat_fields)))
  else
    $error("Input beat dropped or changed while in_ready was low");

  // End of packet holds the input off until the state save has landed
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == STREAM && in_valid && in_ready && in_eop) |=> !in_ready [*DRAIN_CYCLES])
  else
    $error("in_ready rose during the drain after an end-of-packet beat");

  // Load cycle carries no character
  // Save lands three cycles after the registered eop, a load must not read before that
  assert property (@(posedge clk) disable iff (!rst_n)
    load_state |-> (!char_vld &&
                    !(eop || $past(eop, 1) || $past(eop, 2) || $past(eop, 3))))
  else
    $error("State load with a character strobe or with a context save still in flight");

endmodule

/* verification/payload_scanner_tb.sv */
`timescale 1ns/1ps

module payload_scanner_tb;
  import scan_pkg::*;

  localparam int          MAX_ROWS        = 16;
  localparam int          CYCLES_PER_ROW  = 30;
  localparam int          CYCLES_PER_BYTE = 20;
  localparam logic [31:0] LCG_SEED        = 32'h7862_b034;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  logic         in_ready;
  byte_t        in_data;
  logic         in_sop;
  logic         in_eop;
  stream_id_t   in_stream;
  logic         in_flush;
  rule_mask_t   in_enable;
  logic         res_valid;
  stream_id_t   res_stream;
  rule_mask_t   res_fired;
  match_count_t count0;
  match_count_t count1;

  // Stimulus table, one packet per row with its expected result
  string        row_name    [MAX_ROWS];
  stream_id_t   row_stream  [MAX_ROWS];
  logic         row_flush   [MAX_ROWS];
  rule_mask_t   row_enable  [MAX_ROWS];
  string        row_payload [MAX_ROWS];
  rule_mask_t   row_fired   [MAX_ROWS];
  match_count_t row_count0  [MAX_ROWS];
  match_count_t row_count1  [MAX_ROWS];

  int          num_rows     = 0;
  int          total_bytes  = 0;
  int          results_seen = 0;
  bit          table_ready  = 1'b0;
  logic [31:0] lcg_state;

  payload_scanner #(
    .RULE0_LEN     (5),
    .RULE0_PATTERN ("login"),
    .RULE1_LEN     (4),
    .RULE1_PATTERN ("pass")
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_stream  (in_stream),
    .in_flush   (in_flush),
    .in_enable  (in_enable),
    .res_valid  (res_valid),
    .res_stream (res_stream),
    .res_fired  (res_fired),
    .count0     (count0),
    .count1     (count1)
  );

  // Handshake and drain checks on the tracker
  bind stream_tracker payload_scanner_chk chk_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_sop     (in_sop),
    .in_eop     (in_eop),
    .in_stream  (in_stream),
    .in_flush   (in_flush),
    .in_enable  (in_enable),
    .state      (state_q),
    .load_state (load_state),
    .char_vld   (char_vld),
    .eop        (eop)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic add_row(input string name, input stream_id_t stream, input logic flush,
                         input rule_mask_t enable, input string payload,
                         input rule_mask_t fired, input match_count_t c0,
                         input match_count_t c1);
    row_name[num_rows]    = name;
    row_stream[num_rows]  = stream;
    row_flush[num_rows]   = flush;
    row_enable[num_rows]  = enable;
    row_payload[num_rows] = payload;
    row_fired[num_rows]   = fired;
    row_count0[num_rows]  = c0;
    row_count1[num_rows]  = c1;
    total_bytes           = total_bytes + payload.len();
    num_rows              = num_rows + 1;
  endtask

  // Expected fired bits are {pass, login}, counts are running totals
  task automatic build_table();
    add_row("single_match",  6'd1,  1'b0, 2'b11, "xxlogin",    2'b01, 16'd1, 16'd0);
    // Split signatures on two interleaved streams
    add_row("split_lo",      6'd2,  1'b0, 2'b11, "lo",         2'b00, 16'd1, 16'd0);
    add_row("split_pa",      6'd3,  1'b0, 2'b11, "pa",         2'b00, 16'd1, 16'd0);
    add_row("split_gin",     6'd2,  1'b0, 2'b11, "gin",        2'b01, 16'd2, 16'd0);
    add_row("split_ss",      6'd3,  1'b0, 2'b11, "ss",         2'b10, 16'd2, 16'd1);
    // Rule 1 off, no flag, no count and no saved state
    add_row("disabled_pass", 6'd4,  1'b0, 2'b01, "pass",       2'b00, 16'd2, 16'd1);
    add_row("disabled_pa",   6'd5,  1'b0, 2'b01, "pa",         2'b00, 16'd2, 16'd1);
    add_row("enabled_ss",    6'd5,  1'b0, 2'b11, "ss",         2'b00, 16'd2, 16'd1);
    // Flush restarts the automaton from zero
    add_row("flush_lo",      6'd6,  1'b0, 2'b11, "lo",         2'b00, 16'd2, 16'd1);
    add_row("flush_gin",     6'd6,  1'b1, 2'b11, "gin",        2'b00, 16'd2, 16'd1);
    add_row("fallback",      6'd7,  1'b0, 2'b11, "llogin",     2'b01, 16'd3, 16'd1);
    // Two hits in one packet still count one packet
    add_row("repeat_twice",  6'd8,  1'b0, 2'b11, "loginlogin", 2'b01, 16'd4, 16'd1);
    add_row("both_rules",    6'd9,  1'b0, 2'b11, "passlogin",  2'b11, 16'd5, 16'd2);
    add_row("single_beat",   6'd10, 1'b0, 2'b11, "l",          2'b00, 16'd5, 16'd2);
    add_row("rule0_off",     6'd11, 1'b0, 2'b10, "login",      2'b00, 16'd5, 16'd2);
    add_row("rule0_back_on", 6'd11, 1'b0, 2'b11, "pass",       2'b10, 16'd5, 16'd3);
  endtask

  // Idle cycles before a beat, 0 to 2
  function automatic int next_gap();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[31:16] % 16'd3);
  endfunction

  task automatic report_failure();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Hold the beat until in_ready is seen mid-cycle, then pass the transfer edge
  task automatic wait_transfer();
    #1;
    while (!in_ready)
    begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
  endtask

  task automatic send_packet(input int r);
    int n;
    int i;
    int gap;
    n = row_payload[r].len();
    for (i = 0; i < n; i++)
    begin
      gap = next_gap();
      if (gap > 0)
      begin
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        repeat (gap) @(negedge clk);
      end
      // Packet fields ride on every beat, the DUT takes them at sop
      in_valid  = 1'b1;
      in_data   = row_payload[r][i];
      in_sop    = (i == 0);
      in_eop    = (i == n - 1);
      in_stream = row_stream[r];
      in_flush  = row_flush[r];
      in_enable = row_enable[r];
      wait_transfer();
    end
    in_valid = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
  endtask

  // Results come back in table order
  // A pulse past the end of the table only moves the result count
  task automatic check_result();
    int r;
    r = results_seen;
    if (r < num_rows)
    begin
      assert (res_stream == row_stream[r])
      else
      begin
        $display("MISMATCH %s res_stream expected %0d actual %0d",
                 row_name[r], row_stream[r], res_stream);
        report_failure();
      end
      assert (res_fired == row_fired[r])
      else
      begin
        $display("MISMATCH %s res_fired expected %b actual %b",
                 row_name[r], row_fired[r], res_fired);
        report_failure();
      end
      assert (count0 == row_count0[r])
      else
      begin
        $display("MISMATCH %s count0 expected %0d actual %0d", row_name[r], row_count0[r], count0);
        report_failure();
      end
      assert (count1 == row_count1[r])
      else
      begin
        $display("MISMATCH %s count1 expected %0d actual %0d", row_name[r], row_count1[r], count1);
        report_failure();
      end
    end
    results_seen = r + 1;
  endtask

  initial
  begin : result_monitor
    forever
    begin
      @(negedge clk);
      if (rst_n && res_valid)
        check_result();
    end
  end

  initial
  begin : watchdog
    int limit_cycles;
    wait (table_ready);
    limit_cycles = CYCLES_PER_ROW * num_rows + CYCLES_PER_BYTE * total_bytes;
    repeat (limit_cycles) @(posedge clk);
    $display("ERROR: no result before timeout");
    report_failure();
  end

  initial
  begin : stimulus
    int r;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    in_sop    = 1'b0;
    in_eop    = 1'b0;
    in_stream = '0;
    in_flush  = 1'b0;
    in_enable = '0;
    lcg_state = LCG_SEED;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (r = 0; r < num_rows; r++)
      send_packet(r);
    wait (results_seen >= num_rows);
    // A few more cycles so a stray extra result would still show up
    repeat (10) @(negedge clk);
    if (results_seen == num_rows)
    begin
      $display("Test OK");
      $finish;
    end
    else
    begin
      $display("ERROR: expected %0d results, saw %0d", num_rows, results_seen);
      report_failure();
    end
  end

endmodule

/* src.f */
logic/scan_pkg.sv
logic/literal_dfa.sv
logic/rule_context.sv
logic/stream_tracker.sv
logic/payload_scanner.sv
verification/payload_scanner_chk.sv
verification/payload_scanner_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the payload scanner testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=payload_scanner_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f src.f -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The testbench prints its fail line before stopping
if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
